// File: source/lg_consts.svh
//////////////////////////////////////////////////
// widths, table depth and register map of the
// logic pattern generator, include where needed
//////////////////////////////////////////////////
`ifndef LG_CONSTS_SVH
`define LG_CONSTS_SVH

// sample stream and waveform table
`define LG_DW        8                     // sample width
`define LG_AW        8                     // table index width
`define LG_TBL_DEPTH (1 << `LG_AW)         // table entries
`define LG_FW        8                     // pointer fraction
`define LG_PW        (`LG_AW + `LG_FW)     // full pointer
`define LG_BW        16                    // burst counters

// register port, byte addresses
`define LG_BAW 16
`define LG_BDW 32

`define LG_R_CTL     16'h000  // wr: rst/start/stop/swtrg, rd: status
`define LG_R_IRQ_ENA 16'h008
`define LG_R_IRQ_STS 16'h00C  // write one to clear
`define LG_R_TRG_ENA 16'h010
`define LG_R_SIZ     16'h020
`define LG_R_OFF     16'h024
`define LG_R_STE     16'h028
`define LG_R_BMODE   16'h030  // bit0 burst enable, bit1 infinite
`define LG_R_BDL     16'h034
`define LG_R_BNM     16'h03C
`define LG_R_STS_BNM 16'h044
`define LG_R_MSK     16'h050
`define LG_R_VAL     16'h054
`define LG_TBL_BASE  16'h400  // table window, one word per entry

`endif

// File: source/lg_bus_pkg.sv
//////////////////////////////////////////////////
// AXI4-Lite types for the register port
// no wstrb, every write is a full word
//////////////////////////////////////////////////
`include "lg_consts.svh"

package lg_bus_pkg;

  typedef logic [`LG_BAW-1:0] axil_addr_t;  // byte address
  typedef logic [`LG_BDW-1:0] axil_data_t;
  typedef logic [1:0]         axil_resp_t;

  localparam axil_resp_t AXIL_OKAY = 2'b00;

  // manager to subordinate
  typedef struct packed {
    // write address channel
    axil_addr_t awaddr;
    logic       awvalid;
    // write data channel
    axil_data_t wdata;
    logic       wvalid;
    // read address channel
    axil_addr_t araddr;
    logic       arvalid;
    // response side ready
    logic       bready;
    logic       rready;
  } axil_req_t;

  // subordinate to manager
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    axil_resp_t bresp;
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
    axil_resp_t rresp;
  } axil_rsp_t;

endpackage

// File: source/lg_gen_pkg.sv
//////////////////////////////////////////////////
// generator types: sample and pointer vectors,
// config/control/status bundles, stream beat and
// the sequencer state
//////////////////////////////////////////////////
`include "lg_consts.svh"

package lg_gen_pkg;

  typedef logic [`LG_DW-1:0] smp_t;   // one sample
  typedef logic [`LG_AW-1:0] tix_t;   // table index
  typedef logic [`LG_PW-1:0] ptr_t;   // index.fraction
  typedef logic [`LG_BW-1:0] bcnt_t;  // burst length / number

  // table write from the register port
  typedef struct packed {
    logic ena;
    tix_t idx;
    smp_t dat;
  } tbl_wr_t;

  // playback configuration
  typedef struct packed {
    ptr_t  siz;  // table size, fixed point
    ptr_t  off;  // start offset (phase)
    ptr_t  ste;  // step (frequency)
    logic  ben;  // burst mode
    logic  inf;  // endless bursts
    bcnt_t bdl;  // beats per burst
    bcnt_t bnm;  // bursts to play
  } gen_cfg_t;

  // single cycle control pulses
  typedef struct packed {
    logic rst;
    logic str;
    logic stp;
    logic trg;
  } gen_ctl_t;

  typedef struct packed {
    logic  armed;
    logic  running;
    logic  triggered;  // sticky until start/reset
    bcnt_t bnm;        // bursts done
    logic  evt_trg;    // pulse, trigger taken
    logic  evt_lst;    // pulse, final beat left
  } gen_sts_t;

  typedef struct packed {
    smp_t dat;
    logic lst;
  } smp_beat_t;

  typedef enum logic [1:0] {
    IDLE,
    ARMED,
    RUN
  } seq_state_e;

endpackage

// File: source/lg_regs.sv
//////////////////////////////////////////////////
// AXI4-Lite register block of the generator
// config registers, table write path, control
// pulses and the interrupt status
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "lg_consts.svh"

module lg_regs (
  input  logic                  bus,
  input  logic                  ctl_rst,
  input  lg_bus_pkg::axil_req_t axil_req,
  output lg_bus_pkg::axil_rsp_t axil_rsp,
  input  lg_gen_pkg::gen_sts_t  gen_sts,
  input  logic                  trg_in,
  output lg_gen_pkg::gen_cfg_t  gen_cfg,
  output lg_gen_pkg::gen_ctl_t  gen_ctl,
  output lg_gen_pkg::tbl_wr_t   tbl_wr,
  output lg_gen_pkg::smp_t      msk,
  output lg_gen_pkg::smp_t      val,
  output logic                  irq
);
  import lg_bus_pkg::*;
  import lg_gen_pkg::*;

  axil_addr_t waddr;
  axil_data_t wdata;
  axil_data_t rd_mux;
  axil_data_t rdata;     // held read data
  logic       wr_acc;    // write accepted this cycle
  logic       rd_acc;    // read accepted this cycle
  logic       ctl_hit;
  logic       tbl_hit;
  logic       bvalid;
  logic       rvalid;
  logic       trg_ena;
  logic [1:0] irq_ena;   // {last, trigger}
  logic [1:0] irq_sts;
  logic [1:0] irq_set;
  logic [1:0] irq_clr;

  assign waddr  = axil_req.awaddr;
  assign wdata  = axil_req.wdata;
  assign wr_acc = axil_req.awvalid & axil_req.wvalid & ~bvalid;
  assign rd_acc = axil_req.arvalid & ~rvalid;

  assign ctl_hit = wr_acc & (waddr == `LG_R_CTL);
  assign tbl_hit = wr_acc &
                   ((waddr >> (`LG_AW + 2)) == (`LG_TBL_BASE >> (`LG_AW + 2)));

  //////////////////////////////////////////////////
  // handshakes
  //////////////////////////////////////////////////

  assign axil_rsp.awready = wr_acc;  // address and data taken together
  assign axil_rsp.wready  = wr_acc;
  assign axil_rsp.bvalid  = bvalid;
  assign axil_rsp.bresp   = AXIL_OKAY;
  assign axil_rsp.arready = rd_acc;
  assign axil_rsp.rvalid  = rvalid;
  assign axil_rsp.rdata   = rdata;
  assign axil_rsp.rresp   = AXIL_OKAY;

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      bvalid <= 1'b0;
    end else if (wr_acc) begin
      bvalid <= 1'b1;
    end else if (axil_req.bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      rvalid <= 1'b0;
    end else if (rd_acc) begin
      rvalid <= 1'b1;
    end else if (axil_req.rready) begin
      rvalid <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // write decode
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      gen_cfg <= '0;
      irq_ena <= '0;
      trg_ena <= 1'b0;
      msk     <= '0;
      val     <= '0;
    end else if (wr_acc) begin
      case (waddr)
        `LG_R_IRQ_ENA: irq_ena     <= wdata[1:0];
        `LG_R_TRG_ENA: trg_ena     <= wdata[0];
        `LG_R_SIZ:     gen_cfg.siz <= wdata[`LG_PW-1:0];
        `LG_R_OFF:     gen_cfg.off <= wdata[`LG_PW-1:0];
        `LG_R_STE:     gen_cfg.ste <= wdata[`LG_PW-1:0];
        `LG_R_BMODE: begin
          gen_cfg.ben <= wdata[0];
          gen_cfg.inf <= wdata[1];
        end
        `LG_R_BDL:     gen_cfg.bdl <= wdata[`LG_BW-1:0];
        `LG_R_BNM:     gen_cfg.bnm <= wdata[`LG_BW-1:0];
        `LG_R_MSK:     msk         <= wdata[`LG_DW-1:0];
        `LG_R_VAL:     val         <= wdata[`LG_DW-1:0];
        default: ;  // ctl, irq status and table handled below
      endcase
    end
  end

  // table entry lands at acceptance
  assign tbl_wr.ena = tbl_hit;
  assign tbl_wr.idx = waddr[`LG_AW+1:2];  // word addressed
  assign tbl_wr.dat = wdata[`LG_DW-1:0];

  // control pulses, one cycle after the write
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      gen_ctl <= '0;
    end else begin
      gen_ctl.rst <= ctl_hit & wdata[0];
      gen_ctl.str <= ctl_hit & wdata[1];
      gen_ctl.stp <= ctl_hit & wdata[2];
      gen_ctl.trg <= (ctl_hit & wdata[3]) | (trg_ena & trg_in);  // sw or external
    end
  end

  //////////////////////////////////////////////////
  // interrupts
  //////////////////////////////////////////////////

  assign irq_set = {gen_sts.evt_lst, gen_sts.evt_trg} & irq_ena;
  assign irq_clr = (wr_acc && (waddr == `LG_R_IRQ_STS)) ? wdata[1:0] : 2'b00;

  always_ff @(posedge bus) begin
    if (ctl_rst || gen_ctl.rst) begin
      irq_sts <= '0;
    end else begin
      irq_sts <= (irq_sts & ~irq_clr) | irq_set;  // new event beats the clear
    end
  end

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      irq <= 1'b0;
    end else begin
      irq <= |irq_sts;
    end
  end

  //////////////////////////////////////////////////
  // read back
  //////////////////////////////////////////////////

  always_comb begin
    case (axil_req.araddr)
      `LG_R_CTL:     rd_mux = axil_data_t'({gen_sts.triggered,
                                            gen_sts.running,
                                            gen_sts.armed});
      `LG_R_IRQ_ENA: rd_mux = axil_data_t'(irq_ena);
      `LG_R_IRQ_STS: rd_mux = axil_data_t'(irq_sts);
      `LG_R_TRG_ENA: rd_mux = axil_data_t'(trg_ena);
      `LG_R_SIZ:     rd_mux = axil_data_t'(gen_cfg.siz);
      `LG_R_OFF:     rd_mux = axil_data_t'(gen_cfg.off);
      `LG_R_STE:     rd_mux = axil_data_t'(gen_cfg.ste);
      `LG_R_BMODE:   rd_mux = axil_data_t'({gen_cfg.inf, gen_cfg.ben});
      `LG_R_BDL:     rd_mux = axil_data_t'(gen_cfg.bdl);
      `LG_R_BNM:     rd_mux = axil_data_t'(gen_cfg.bnm);
      `LG_R_STS_BNM: rd_mux = axil_data_t'(gen_sts.bnm);
      `LG_R_MSK:     rd_mux = axil_data_t'(msk);
      `LG_R_VAL:     rd_mux = axil_data_t'(val);
      default:       rd_mux = '0;  // table window too, write only
    endcase
  end

  always_ff @(posedge bus) begin
    if (rd_acc) begin
      rdata <= rd_mux;
    end
  end

endmodule

// File: source/lg_seq.sv
//////////////////////////////////////////////////
// sequencer: arm on start, run on trigger, walk
// the table with a fixed point pointer
// two stages, pointer then synchronous table read
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "lg_consts.svh"

module lg_seq (
  input  logic                  bus,
  input  logic                  ctl_rst,
  input  lg_gen_pkg::gen_cfg_t  gen_cfg,
  input  lg_gen_pkg::gen_ctl_t  gen_ctl,
  input  lg_gen_pkg::tbl_wr_t   tbl_wr,
  input  logic                  seq_ready,
  output lg_gen_pkg::gen_sts_t  gen_sts,
  output logic                  seq_valid,
  output lg_gen_pkg::smp_beat_t seq_beat
);
  import lg_gen_pkg::*;

  seq_state_e      state;
  smp_t            mem [`LG_TBL_DEPTH];  // waveform table
  ptr_t            ptr;
  ptr_t            ptr_nxt;
  logic [`LG_PW:0] ptr_sum;    // spare bit for the wrap compare
  bcnt_t           bln;        // beat within burst
  bcnt_t           bnm_cnt;    // bursts issued
  logic            triggered;
  logic            flush;      // stop or soft reset
  logic            adv;        // both stages move
  logic            issue;      // new beat into stage 1
  logic            bst_end;    // beat closes a burst
  logic            bst_fin;    // ... and it is the final one
  logic            s1_vld;
  tix_t            s1_idx;
  logic            s1_lst;
  logic            s1_fin;
  logic            s2_fin;

  assign flush = gen_ctl.rst | gen_ctl.stp;
  assign adv   = ~seq_valid | seq_ready;  // frozen while output stalls
  assign issue = (state == RUN) & adv;

  assign bst_end = gen_cfg.ben & (bln == bcnt_t'(gen_cfg.bdl - 1'b1));
  assign bst_fin = bst_end & ~gen_cfg.inf &
                   (bcnt_t'(bnm_cnt + 1'b1) == gen_cfg.bnm);

  // step and wrap modulo siz
  assign ptr_sum = {1'b0, ptr} + {1'b0, gen_cfg.ste};
  assign ptr_nxt = (ptr_sum >= {1'b0, gen_cfg.siz}) ?
                   ptr_t'(ptr_sum - {1'b0, gen_cfg.siz}) : ptr_t'(ptr_sum);

  //////////////////////////////////////////////////
  // FSM, pointer and burst counters
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst || gen_ctl.rst) begin
      state     <= IDLE;
      ptr       <= '0;
      bln       <= '0;
      bnm_cnt   <= '0;
      triggered <= 1'b0;
    end else if (gen_ctl.stp) begin
      state <= IDLE;  // counters stay readable
    end else begin
      case (state)
        IDLE: begin
          if (gen_ctl.str) begin
            state     <= ARMED;
            ptr       <= gen_cfg.off;
            bln       <= '0;
            bnm_cnt   <= '0;
            triggered <= 1'b0;
          end
        end
        ARMED: begin
          if (gen_ctl.trg) begin
            state     <= RUN;
            triggered <= 1'b1;
          end
        end
        RUN: begin
          if (issue) begin
            if (bst_end) begin
              ptr     <= gen_cfg.off;  // each burst restarts
              bln     <= '0;
              bnm_cnt <= bnm_cnt + 1'b1;
              if (bst_fin) begin
                state <= IDLE;  // in flight beats still drain
              end
            end else begin
              ptr <= ptr_nxt;
              bln <= bln + 1'b1;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // pipeline
  //////////////////////////////////////////////////

  // stage 1, sample the integer part
  always_ff @(posedge bus) begin
    if (ctl_rst || flush) begin
      s1_vld <= 1'b0;
    end else if (adv) begin
      s1_vld <= issue;
    end
  end

  always_ff @(posedge bus) begin
    if (adv) begin
      s1_idx <= ptr[`LG_PW-1:`LG_FW];
      s1_lst <= bst_end;
      s1_fin <= bst_fin;
    end
  end

  // stage 2, table write port and registered read
  always_ff @(posedge bus) begin
    if (tbl_wr.ena) begin
      mem[tbl_wr.idx] <= tbl_wr.dat;
    end
    if (adv) begin
      seq_beat.dat <= mem[s1_idx];
      seq_beat.lst <= s1_lst;
      s2_fin       <= s1_fin;
    end
  end

  always_ff @(posedge bus) begin
    if (ctl_rst || flush) begin
      seq_valid <= 1'b0;
    end else if (adv) begin
      seq_valid <= s1_vld;
    end
  end

  // status back to the register block
  assign gen_sts.armed     = (state == ARMED);
  assign gen_sts.running   = (state == RUN);
  assign gen_sts.triggered = triggered;
  assign gen_sts.bnm       = bnm_cnt;
  assign gen_sts.evt_trg   = (state == ARMED) & gen_ctl.trg & ~flush;
  assign gen_sts.evt_lst   = seq_valid & seq_ready & s2_fin;  // final beat leaves

endmodule

// File: source/lg_out.sv
//////////////////////////////////////////////////
// output stage: mask/value forcing and one
// stream register with back-pressure
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lg_out (
  input  logic                  bus,
  input  logic                  ctl_rst,
  input  logic                  seq_valid,
  input  lg_gen_pkg::smp_beat_t seq_beat,
  output logic                  seq_ready,
  input  lg_gen_pkg::smp_t      msk,
  input  lg_gen_pkg::smp_t      val,
  output logic                  sto_valid,
  output lg_gen_pkg::smp_beat_t sto_beat,
  input  logic                  sto_ready
);
  import lg_gen_pkg::*;

  smp_t frc;  // forced sample

  // mask set passes table bit, clear takes value bit
  assign frc = (msk & seq_beat.dat) | (~msk & val);

  // take a beat when empty or being emptied
  assign seq_ready = ~sto_valid | sto_ready;

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      sto_valid <= 1'b0;
    end else if (seq_ready) begin
      sto_valid <= seq_valid;
    end
  end

  always_ff @(posedge bus) begin
    if (seq_valid && seq_ready) begin
      sto_beat.dat <= frc;
      sto_beat.lst <= seq_beat.lst;
    end
  end

endmodule

// File: source/lg_top.sv
//////////////////////////////////////////////////
// logic generator top: register block, sequencer
// and output stage, wires only
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lg_top (
  input  logic                  bus,
  input  logic                  ctl_rst,
  input  lg_bus_pkg::axil_req_t axil_req,
  output lg_bus_pkg::axil_rsp_t axil_rsp,
  input  logic                  trg_in,
  output logic                  sto_valid,
  output lg_gen_pkg::smp_beat_t sto_beat,
  input  logic                  sto_ready,
  output logic                  irq
);
  import lg_gen_pkg::*;

  gen_cfg_t  gen_cfg;
  gen_ctl_t  gen_ctl;
  gen_sts_t  gen_sts;
  tbl_wr_t   tbl_wr;
  smp_t      msk;
  smp_t      val;
  logic      seq_valid;
  logic      seq_ready;
  smp_beat_t seq_beat;

  lg_regs i_regs (
    .bus      (bus),
    .ctl_rst  (ctl_rst),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .gen_sts  (gen_sts),
    .trg_in   (trg_in),
    .gen_cfg  (gen_cfg),
    .gen_ctl  (gen_ctl),
    .tbl_wr   (tbl_wr),
    .msk      (msk),
    .val      (val),
    .irq      (irq)
  );

  lg_seq i_seq (
    .bus       (bus),
    .ctl_rst   (ctl_rst),
    .gen_cfg   (gen_cfg),
    .gen_ctl   (gen_ctl),
    .tbl_wr    (tbl_wr),
    .seq_ready (seq_ready),
    .gen_sts   (gen_sts),
    .seq_valid (seq_valid),
    .seq_beat  (seq_beat)
  );

  lg_out i_out (
    .bus       (bus),
    .ctl_rst   (ctl_rst),
    .seq_valid (seq_valid),
    .seq_beat  (seq_beat),
    .seq_ready (seq_ready),
    .msk       (msk),
    .val       (val),
    .sto_valid (sto_valid),
    .sto_beat  (sto_beat),
    .sto_ready (sto_ready)
  );

endmodule

// File: bench/lg_chk.sv
//////////////////////////////////////////////////
// handshake assertions, bound into the generator
// top from the testbench
//////////////////////////////////////////////////
`timescale 1ns/1ps

module lg_chk (
  input logic                   bus,
  input logic                   ctl_rst,
  input lg_bus_pkg::axil_req_t  axil_req,
  input lg_bus_pkg::axil_rsp_t  axil_rsp,
  input logic                   sto_valid,
  input lg_gen_pkg::smp_beat_t  sto_beat,
  input logic                   sto_ready,
  input lg_gen_pkg::seq_state_e state
);
  import lg_gen_pkg::*;

  int fail_cnt = 0;  // read by the testbench

  // stalled beat stays put
  a_sto_hold: assert property (@(posedge bus) disable iff (ctl_rst)
    sto_valid && !sto_ready |=> sto_valid && $stable(sto_beat))
    else begin
      $error("stream beat moved while stalled");
      fail_cnt++;
    end

  a_b_hold: assert property (@(posedge bus) disable iff (ctl_rst)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else begin
      $error("bvalid dropped before bready");
      fail_cnt++;
    end

  a_r_hold: assert property (@(posedge bus) disable iff (ctl_rst)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
    else begin
      $error("rvalid dropped before rready");
      fail_cnt++;
    end

  a_rst_quiet: assert property (@(posedge bus) ctl_rst |=> !sto_valid)
    else begin
      $error("sto_valid high after reset");
      fail_cnt++;
    end

  a_state: assert property (@(posedge bus) disable iff (ctl_rst)
    state inside {IDLE, ARMED, RUN})
    else begin
      $error("sequencer state out of range");
      fail_cnt++;
    end

endmodule

// File: bench/lg_tb.sv
//////////////////////////////////////////////////
// testbench of the logic pattern generator
// replays the command list in bench/lg_input.txt
// register accesses, triggers and expected beats
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "lg_consts.svh"

module lg_tb;
  import lg_bus_pkg::*;
  import lg_gen_pkg::*;

  localparam int TMO = 2000;  // cycles per wait

  logic        bus;
  logic        ctl_rst;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  logic        trg_in;
  logic        sto_valid;
  smp_beat_t   sto_beat;
  logic        sto_ready = 1'b1;
  logic        irq;

  logic [51:0] cmd [0:127];         // op, addr, data
  smp_beat_t   got [$];             // beats taken off the stream
  logic [31:0] lfsr = 32'h7f20;
  logic        rnd_ready = 1'b0;    // random back-pressure on
  bit          aborted = 1'b0;      // a wait ran out
  int          err_cnt = 0;
  int          tst_err = 0;
  int          tst_cnt = 0;
  int          tst_bad = 0;

  lg_top i_lg_top (
    .bus       (bus),
    .ctl_rst   (ctl_rst),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .trg_in    (trg_in),
    .sto_valid (sto_valid),
    .sto_beat  (sto_beat),
    .sto_ready (sto_ready),
    .irq       (irq)
  );

  bind lg_top lg_chk i_chk (
    .bus       (bus),
    .ctl_rst   (ctl_rst),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .sto_valid (sto_valid),
    .sto_beat  (sto_beat),
    .sto_ready (sto_ready),
    .state     (i_seq.state)
  );

  initial begin
    bus = 1'b0;
    forever #20 bus = ~bus;  // 40 ns
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  always @(posedge bus) begin
    if (rnd_ready) begin
      lfsr = lfsr_step(lfsr);  // one step per ready bit
      sto_ready <= lfsr[0];
    end else begin
      sto_ready <= 1'b1;
    end
  end

  // stream monitor keeps every transfer in order
  always @(posedge bus) begin
    if (sto_valid && sto_ready) begin
      got.push_back(sto_beat);
    end
  end

  //////////////////////////////////////////////////
  // AXI4-Lite manager
  //////////////////////////////////////////////////

  task automatic axil_write(input logic [15:0] addr, input logic [31:0] data);
    int t;
    t = 0;
    @(posedge bus);
    axil_req.awaddr  <= addr;
    axil_req.awvalid <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wvalid  <= 1'b1;
    do begin
      @(posedge bus);
      t++;
    end while (!(axil_rsp.awready && axil_rsp.wready) && t < TMO);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    if (!(axil_rsp.awready && axil_rsp.wready)) begin
      $display("write to %h was never accepted (%0t)", addr, $time);
      aborted = 1'b1;
      return;
    end
    t = 0;
    do begin
      @(posedge bus);
      t++;
    end while (!axil_rsp.bvalid && t < TMO);
    if (!axil_rsp.bvalid) begin
      $display("no write response for %h (%0t)", addr, $time);
      aborted = 1'b1;
      return;
    end
    if (axil_rsp.bresp != AXIL_OKAY) begin
      $display("ERR %0t: write %h bresp %b", $time, addr, axil_rsp.bresp);
      tst_err++;
    end
    axil_req.bready <= 1'b1;  // late ready lets bvalid wait a cycle
    @(posedge bus);
    axil_req.bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [15:0] addr, output logic [31:0] data);
    int t;
    t = 0;
    data = '0;
    @(posedge bus);
    axil_req.araddr  <= addr;
    axil_req.arvalid <= 1'b1;
    do begin
      @(posedge bus);
      t++;
    end while (!axil_rsp.arready && t < TMO);
    axil_req.arvalid <= 1'b0;
    if (!axil_rsp.arready) begin
      $display("read of %h was never accepted (%0t)", addr, $time);
      aborted = 1'b1;
      return;
    end
    t = 0;
    do begin
      @(posedge bus);
      t++;
    end while (!axil_rsp.rvalid && t < TMO);
    if (!axil_rsp.rvalid) begin
      $display("no read data for %h (%0t)", addr, $time);
      aborted = 1'b1;
      return;
    end
    data = axil_rsp.rdata;
    if (axil_rsp.rresp != AXIL_OKAY) begin
      $display("ERR %0t: read %h rresp %b", $time, addr, axil_rsp.rresp);
      tst_err++;
    end
    axil_req.rready <= 1'b1;  // late ready lets rvalid wait a cycle
    @(posedge bus);
    axil_req.rready <= 1'b0;
  endtask

  // entry i holds i + base
  task automatic fill_table(input smp_t base);
    int i;
    for (i = 0; i < `LG_TBL_DEPTH && !aborted; i++) begin
      axil_write(16'(`LG_TBL_BASE + 4 * i), {24'h0, smp_t'(i + int'(base))});
    end
  endtask

  // ctl[3:0] beats, ctl[7:4] last flags, samples low byte first
  task automatic expect_beats(input logic [15:0] ctl, input logic [31:0] dat);
    smp_beat_t b;
    int        k;
    int        t;
    for (k = 0; k < int'(ctl[3:0]); k++) begin
      t = 0;
      while (got.size() == 0 && t < TMO) begin
        @(posedge bus);
        t++;
      end
      if (got.size() == 0) begin
        $display("stream stalled, beat %0d never came (%0t)", k, $time);
        aborted = 1'b1;
        return;
      end
      b = got.pop_front();
      if (b.dat != dat[8*k +: 8] || b.lst != ctl[4+k]) begin
        $display("ERR %0t: beat %h/%b, expected %h/%b", $time, b.dat, b.lst,
                 dat[8*k +: 8], ctl[4+k]);
        tst_err++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // command loop
  //////////////////////////////////////////////////

  initial begin
    int          pc;
    int          t;
    logic [3:0]  op;
    logic [15:0] addr;
    logic [31:0] data;
    logic [31:0] rd;
    ctl_rst  = 1'b1;
    axil_req = '0;
    trg_in   = 1'b0;
    pc       = 0;
    $readmemh("bench/lg_input.txt", cmd);
    repeat (16) @(posedge bus);
    ctl_rst <= 1'b0;
    while (!aborted && pc <= $high(cmd) && cmd[pc][51:48] != 4'h0) begin
      {op, addr, data} = cmd[pc];
      pc++;
      case (op)
        4'h1: axil_write(addr, data);
        4'h2: begin
          axil_read(addr, rd);
          if (!aborted && rd != data) begin
            $display("ERR %0t: read %h got %h, expected %h", $time, addr, rd, data);
            tst_err++;
          end
        end
        4'h3: expect_beats(addr, data);
        4'h4: rnd_ready <= data[0];
        4'h5: begin  // one cycle on trg_in
          @(posedge bus);
          trg_in <= 1'b1;
          @(posedge bus);
          trg_in <= 1'b0;
        end
        4'h6: begin  // stream must stay quiet
          repeat (data) @(posedge bus);
          if (got.size() != 0) begin
            $display("ERR %0t: %0d extra beats", $time, got.size());
            tst_err++;
            got.delete();
          end
        end
        4'h7: begin
          t = 0;
          while (irq != data[0] && t < TMO) begin
            @(posedge bus);
            t++;
          end
          if (irq != data[0]) begin
            $display("irq never went to %b (%0t)", data[0], $time);
            aborted = 1'b1;
          end
        end
        4'h8: fill_table(data[7:0]);
        4'h9: begin  // drop beats still draining
          repeat (4) @(posedge bus);
          got.delete();
        end
        4'hf: begin
          $display("test %0d done, %0d errors", data, tst_err);
          tst_cnt++;
          if (tst_err != 0) begin
            tst_bad++;
          end
          err_cnt += tst_err;
          tst_err = 0;
        end
        default: begin
          $display("unknown command %h on entry %0d", op, pc - 1);
          aborted = 1'b1;
        end
      endcase
    end
    err_cnt += tst_err;
    $display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
             tst_cnt, tst_bad, err_cnt, i_lg_top.i_chk.fail_cnt);
    if (aborted || err_cnt != 0 || i_lg_top.i_chk.fail_cnt != 0) begin
      $display("Simulation failed");
    end else begin
      $display("Simulation passed");
    end
    $finish;
  end

endmodule

// File: bench/lg_input.txt
// op_addr_data, op 1 write, 2 read and compare, 3 beats (addr: last flags, count),
// 4 random ready, 5 trg_in pulse, 6 quiet cycles, 7 wait irq, 8 ramp table, 9 drop, f end
1_0020_00000600
2_0020_00000600
1_0024_00000100
2_0024_00000100
1_0028_00000180
2_0028_00000180
1_0034_00000005
2_0034_00000005
1_003c_00000003
2_003c_00000003
1_0050_000000ff
2_0050_000000ff
1_0054_000000a5
2_0054_000000a5
f_0000_00000001
8_0000_00000010
1_0000_00000002
1_0000_00000008
3_0004_15141211
3_0004_15141211
1_0000_00000004
9_0000_00000000
6_0000_00000014
f_0000_00000002
4_0000_00000001
1_0000_00000002
1_0000_00000008
3_0004_15141211
3_0004_15141211
4_0000_00000000
1_0000_00000004
9_0000_00000000
6_0000_00000014
f_0000_00000003
1_0030_00000001
1_0000_00000002
1_0000_00000008
3_0004_15141211
3_0011_00000011
3_0004_15141211
3_0011_00000011
3_0004_15141211
3_0011_00000011
6_0000_00000014
2_0044_00000003
f_0000_00000004
1_003c_00000001
1_0050_0000003c
1_0000_00000002
1_0000_00000008
3_0004_95959191
3_0011_00000091
6_0000_00000014
1_0050_000000ff
f_0000_00000005
1_0008_00000002
1_0000_00000002
5_0000_00000000
6_0000_00000014
2_0000_00000001
1_0010_00000001
5_0000_00000000
3_0004_15141211
3_0011_00000011
7_0000_00000001
2_000c_00000002
1_000c_00000002
7_0000_00000000
f_0000_00000006
0_0000_00000000

// File: files.f
+incdir+source
source/lg_bus_pkg.sv
source/lg_gen_pkg.sv
source/lg_regs.sv
source/lg_seq.sv
source/lg_out.sv
source/lg_top.sv
bench/lg_chk.sv
bench/lg_tb.sv

// File: run.sh
#!/bin/sh
# build the logic generator testbench with Verilator and run it
# exit status is zero only when the pass line shows up
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module lg_tb -f files.f
out=$(./obj_dir/Vlg_tb) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Simulation passed'
